// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= uopDecodeStageTb
RTL_TOP   ?= uopDecodeStage
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: build.f
+incdir+sim
logic/uopPkg.sv
logic/fetchDecodeReg.sv
logic/uopSequencer.sv
logic/uopControlDecoder.sv
logic/uopDecodeStage.sv
sim/uopDecodeStageTb.sv

// File: logic/fetchDecodeReg.sv
// Fetch to decode register
`default_nettype none

module fetchDecodeReg (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush, // drop the held instruction
	input  logic             stall, // hold while a micro-op pair is in flight
	input  logic             fetchValid,
	input  uopPkg::instrWord instrF,
	output uopPkg::instrWord instrD,
	output logic             validD
);

	// valid bit is control state, cleared by reset and flush
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			validD <= 1'b0; // bubble into decode
		end else if (!stall) begin
			validD <= fetchValid; // take the new fetch slot
		end
	end

	// instruction payload just follows the enable
	always_ff @(posedge clk) begin
		if (!stall) begin
			instrD <= instrF; // held under stall for the second micro-op
		end
	end

endmodule

`default_nettype wire

// File: logic/uopControlDecoder.sv
// Micro-op control decoder
`default_nettype none

module uopControlDecoder #(
	parameter int unsigned ScratchReg = 16
) (
	input  uopPkg::uopBundle uop,
	output uopPkg::ctrlWord  ctrl
);
	import uopPkg::*;

	localparam logic [4:0] scratchAddr = 5'(ScratchReg);

	dpFields  dp;
	mulFields mul;
	logic     isMul;
	logic     isRegShift; // Rs supplies the shift amount
	logic     isCompare; // TST TEQ CMP CMN
	aluOp     dpOp;

	// extend a 4-bit field to the 5-bit register space
	function automatic logic [4:0] regAddr(input logic hi, input logic [3:0] field);
		return {hi & scratchAddr[4], field};
	endfunction

	assign dp         = uop.instr;
	assign mul        = uop.instr;
	assign isMul      = (mul.marker == 4'b1001);
	assign isRegShift = !dp.kind[0] && !dp.op2[7] && dp.op2[4];
	assign isCompare  = (dp.opcode[3:2] == 2'b10);

	always_comb begin
		case (dp.opcode)
			opAnd, opTst: dpOp = aluAnd; // TST is a flag-only AND
			opEor, opTeq: dpOp = aluEor;
			opSub, opCmp: dpOp = aluSub;
			opRsb:        dpOp = aluRsb;
			opAdd, opCmn: dpOp = aluAdd;
			opOrr:        dpOp = aluOrr;
			opMov:        dpOp = aluMov;
			default:      dpOp = aluNop; // carry and bit-clear ops not handled here
		endcase
	end

	always_comb begin
		ctrl       = '0;
		ctrl.valid = uop.valid;
		ctrl.cond  = dp.cond; // carried, evaluated later
		ctrl.op    = aluNop;

		if (uop.valid) begin
			if (isMul) begin
				ctrl.op       = aluMul;
				ctrl.wa3      = regAddr(uop.sel.wa3Hi, mul.rd);
				ctrl.ra1      = regAddr(uop.sel.ra1Hi, mul.rm);
				ctrl.ra2      = regAddr(uop.sel.ra2Hi, mul.rs);
				ctrl.regWrite = 1'b1;
			end else begin
				ctrl.op       = dpOp;
				ctrl.wa3      = regAddr(uop.sel.wa3Hi, dp.rd);
				// register shift reads Rs on port 1, only MOV gets here
				ctrl.ra1      = regAddr(uop.sel.ra1Hi, isRegShift ? dp.op2[11:8] : dp.rn);
				ctrl.regWrite = !isCompare && (dpOp != aluNop);
				ctrl.immOp    = dp.kind[0];
				if (dp.kind[0]) begin
					ctrl.imm12 = dp.op2; // rotate and imm8 kept packed
				end else begin
					ctrl.ra2       = regAddr(uop.sel.ra2Hi, dp.op2[3:0]);
					ctrl.shiftType = dp.op2[6:5];
					if (!isRegShift) begin
						ctrl.shamt = dp.op2[11:7]; // immediate shift amount
					end
				end
			end
			ctrl.setFlags = dp.s && !uop.noFlags; // S sits at bit 20 in both forms
			ctrl.keepV    = uop.keepV;
		end
	end

endmodule

`default_nettype wire

// File: logic/uopDecodeStage.sv
// Decode stage top
`default_nettype none

module uopDecodeStage #(
	parameter int unsigned ScratchReg = 16 // bit 4 must be set
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetchValid,
	input  logic             flush,
	input  uopPkg::instrWord instrF,
	output uopPkg::ctrlWord  ctrlD,
	output logic             stallD
);
	import uopPkg::*;

	instrWord instrD; // held instruction
	logic     validD;
	uopBundle uop; // sequencer to decoder

	fetchDecodeReg fdReg (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.stall      (stallD), // stage stalls itself
		.fetchValid (fetchValid),
		.instrF     (instrF),
		.instrD     (instrD),
		.validD     (validD)
	);

	uopSequencer #(
		.ScratchReg (ScratchReg)
	) seq (
		.clk    (clk),
		.rst    (rst),
		.flush  (flush),
		.instrD (instrD),
		.validD (validD),
		.uop    (uop),
		.stall  (stallD)
	);

	uopControlDecoder #(
		.ScratchReg (ScratchReg)
	) dec (
		.uop  (uop),
		.ctrl (ctrlD)
	);

endmodule

`default_nettype wire

// File: logic/uopPkg.sv
// Micro-op decode types
`default_nettype none

package uopPkg;

	typedef logic [31:0] instrWord; // raw fetched instruction

	typedef struct packed {
		logic [3:0]  cond; // condition code, only carried
		logic [2:0]  kind; // bits 27:25, bit 25 is the immediate flag
		logic [3:0]  opcode; // data-processing opcode
		logic        s; // update flags
		logic [3:0]  rn; // first operand
		logic [3:0]  rd; // destination
		logic [11:0] op2; // shifter operand or rotated immediate
	} dpFields;

	typedef struct packed {
		logic [3:0] cond;
		logic [5:0] kind; // zero for the multiply group
		logic       acc; // set for MLA
		logic       s;
		logic [3:0] rd; // product destination
		logic [3:0] ra; // accumulate operand
		logic [3:0] rs;
		logic [3:0] marker; // 1001 marks a multiply
		logic [3:0] rm;
	} mulFields;

	// raw data-processing opcodes
	localparam logic [3:0] opAnd = 4'b0000;
	localparam logic [3:0] opEor = 4'b0001;
	localparam logic [3:0] opSub = 4'b0010;
	localparam logic [3:0] opRsb = 4'b0011;
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] opTst = 4'b1000;
	localparam logic [3:0] opTeq = 4'b1001;
	localparam logic [3:0] opCmp = 4'b1010;
	localparam logic [3:0] opCmn = 4'b1011;
	localparam logic [3:0] opOrr = 4'b1100;
	localparam logic [3:0] opMov = 4'b1101;

	typedef enum logic [1:0] {ready, rsrSecond, mlaSecond} seqState;

	typedef enum logic [3:0] {
		aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluOrr, aluMov, aluMul, aluNop
	} aluOp;

	typedef struct packed {
		logic wa3Hi; // bit 4 of the write address
		logic ra2Hi;
		logic ra1Hi;
	} regSel;

	typedef struct packed {
		instrWord instr; // micro-op in ARM encoding
		regSel    sel; // scratch register reach
		logic     noFlags; // suppress flag update
		logic     keepV; // leave V untouched
		logic     valid;
	} uopBundle;

	typedef struct packed {
		logic       valid;
		logic [3:0] cond;
		aluOp       op;
		logic       setFlags;
		logic       keepV;
		logic       regWrite;
		logic       immOp; // operand 2 is the rotated immediate
		logic [4:0] wa3;
		logic [4:0] ra1;
		logic [4:0] ra2;
		logic [1:0] shiftType;
		logic [4:0] shamt;
		logic [11:0] imm12;
	} ctrlWord;

endpackage

`default_nettype wire

// File: logic/uopSequencer.sv
// Micro-op sequencer
`default_nettype none

module uopSequencer #(
	parameter int unsigned ScratchReg = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  uopPkg::instrWord instrD,
	input  logic             validD,
	output uopPkg::uopBundle uop,
	output logic             stall // high in the first micro-op of a pair
);
	import uopPkg::*;

	localparam logic [4:0] scratchAddr = 5'(ScratchReg); // bit 4 comes back via regSel

	seqState  state;
	seqState  nextState;
	dpFields  dp; // instruction seen as data processing
	mulFields mul; // same bits seen as multiply
	dpFields  rsrMov; // MOV scratch, Rm shifted by Rs
	dpFields  rsrOp; // original op reading scratch
	mulFields mulOp; // MUL into scratch
	dpFields  mlaAdd; // ADD Rd, Ra, scratch
	logic     isRsr;
	logic     isMla;

	assign dp  = instrD;
	assign mul = instrD;

	// register shifted by register: bits 27:25 zero, bit 7 low, bit 4 high
	assign isRsr = (dp.kind == 3'b000) && !dp.op2[7] && dp.op2[4];
	assign isMla = mul.acc && (mul.marker == 4'b1001); // multiply with accumulate

	// micro-op words, built from the held instruction
	always_comb begin
		rsrMov        = dp;
		rsrMov.opcode = opMov;
		rsrMov.s      = 1'b0; // no flags from the shift step
		rsrMov.rn     = 4'b0000; // MOV ignores Rn
		rsrMov.rd     = scratchAddr[3:0]; // low bits, wa3Hi supplies bit 4

		rsrOp     = dp;
		rsrOp.op2 = {8'b0, scratchAddr[3:0]}; // shift gone, Rm becomes scratch

		mulOp      = mul;
		mulOp.kind = 6'b000000;
		mulOp.acc  = 1'b0; // plain MUL
		mulOp.s    = 1'b0;
		mulOp.rd   = scratchAddr[3:0];
		mulOp.ra   = 4'b0000;

		mlaAdd        = '0;
		mlaAdd.cond   = mul.cond;
		mlaAdd.kind   = 3'b000; // register operand, zero shift
		mlaAdd.opcode = opAdd;
		mlaAdd.s      = mul.s; // flags follow the MLA S bit
		mlaAdd.rn     = mul.ra;
		mlaAdd.rd     = mul.rd;
		mlaAdd.op2    = {8'b0, scratchAddr[3:0]};
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= ready; // abandon any half-issued pair
		end else begin
			state <= nextState;
		end
	end

	// Mealy outputs, the first micro-op leaves in the same cycle as the instruction
	always_comb begin
		nextState   = ready;
		uop.instr   = instrD; // pass-through by default
		uop.sel     = '0;
		uop.noFlags = 1'b0;
		uop.keepV   = 1'b0;
		uop.valid   = validD; // invalid gives a bubble
		stall       = 1'b0;

		case (state)
			ready: begin
				if (validD && isRsr) begin
					uop.instr     = rsrMov;
					uop.sel.wa3Hi = 1'b1; // write scratch
					uop.noFlags   = 1'b1;
					stall         = 1'b1;
					nextState     = rsrSecond;
				end else if (validD && isMla) begin
					uop.instr     = mulOp;
					uop.sel.wa3Hi = 1'b1;
					uop.noFlags   = 1'b1;
					stall         = 1'b1;
					nextState     = mlaSecond;
				end
			end
			rsrSecond: begin
				uop.instr     = rsrOp;
				uop.sel.ra2Hi = 1'b1; // Rm read from scratch
			end
			mlaSecond: begin
				uop.instr     = mlaAdd;
				uop.sel.ra2Hi = 1'b1;
				uop.keepV     = 1'b1; // MLA leaves V alone
			end
			default: begin
				nextState = ready; // unused code, recover
			end
		endcase
	end

endmodule

`default_nettype wire

// File: sim/uopRefModel.svh
// Decode stage reference model
`ifndef UOP_REF_MODEL_SVH
`define UOP_REF_MODEL_SVH

// instruction opcode field to ALU operation
function automatic aluOp refAluOp(input logic [3:0] opc);
	case (opc)
		4'b0000, 4'b1000: return aluAnd; // AND, TST
		4'b0001, 4'b1001: return aluEor; // EOR, TEQ
		4'b0010, 4'b1010: return aluSub; // SUB, CMP
		4'b0011:          return aluRsb;
		4'b0100, 4'b1011: return aluAdd; // ADD, CMN
		4'b1100:          return aluOrr;
		4'b1101:          return aluMov;
		default:          return aluNop;
	endcase
endfunction

// one or two expected control words for an accepted instruction
function automatic void expandInstr(input instrWord w, output int n,
		output ctrlWord e0, output ctrlWord e1);
	logic [4:0] scratch;
	logic       compare;
	scratch    = 5'(ScratchReg);
	compare    = (w[24:23] == 2'b10); // TST TEQ CMP CMN write nothing
	e0         = '0;
	e0.valid   = 1'b1;
	e0.cond    = w[31:28];
	e1         = e0;
	n          = 1;
	if (w[27:25] == 3'b000 && !w[7] && w[4]) begin
		n            = 2; // RSR: shift into scratch, then the op
		e0.op        = aluMov;
		e0.regWrite  = 1'b1;
		e0.wa3       = scratch;
		e0.ra1       = {1'b0, w[11:8]}; // Rs
		e0.ra2       = {1'b0, w[3:0]};
		e0.shiftType = w[6:5];
		e1.op        = refAluOp(w[24:21]);
		e1.setFlags  = w[20];
		e1.regWrite  = !compare;
		e1.wa3       = {1'b0, w[15:12]};
		e1.ra1       = {1'b0, w[19:16]};
		e1.ra2       = scratch;
	end else if (w[7:4] == 4'b1001) begin
		e0.op       = aluMul;
		e0.regWrite = 1'b1;
		e0.ra1      = {1'b0, w[3:0]}; // Rm
		e0.ra2      = {1'b0, w[11:8]}; // Rs
		if (w[21]) begin
			n           = 2; // MLA: product into scratch, then the add
			e0.wa3      = scratch;
			e1.op       = aluAdd;
			e1.setFlags = w[20];
			e1.keepV    = 1'b1;
			e1.regWrite = 1'b1;
			e1.wa3      = {1'b0, w[19:16]};
			e1.ra1      = {1'b0, w[15:12]}; // Ra
			e1.ra2      = scratch;
		end else begin
			e0.wa3      = {1'b0, w[19:16]};
			e0.setFlags = w[20];
		end
	end else begin
		e0.op       = refAluOp(w[24:21]);
		e0.setFlags = w[20];
		e0.regWrite = !compare;
		e0.wa3      = {1'b0, w[15:12]};
		e0.ra1      = {1'b0, w[19:16]};
		e0.immOp    = w[25];
		if (w[25]) begin
			e0.imm12 = w[11:0];
		end else begin
			e0.ra2       = {1'b0, w[3:0]};
			e0.shiftType = w[6:5];
			e0.shamt     = w[11:7];
		end
	end
endfunction

// 16-bit Galois LFSR, one step per bit
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

// File: sim/uopDecodeStageTb.sv
// Decode stage testbench
`default_nettype none

module uopDecodeStageTb;
	timeunit 1ns;
	timeprecision 100ps;
	import uopPkg::*;

	localparam int unsigned ScratchReg = 16;

	`include "uopRefModel.svh"

	logic     clk = 1'b0;
	logic     rst;
	logic     fetchValid;
	logic     flush;
	instrWord instrF;
	ctrlWord  ctrlD;
	logic     stallD;

	ctrlWord     expQ[$]; // expected words in output order
	logic        stallQ[$]; // expected stallD beside each word
	ctrlWord     expWord;
	logic        expStall;
	logic [15:0] lfsrState = 16'd23;
	string       testName = "reset";
	int          errCount = 0;
	int          errBefore;
	int          testCount = 0;
	bit          timedOut = 1'b0;
	instrWord    rw;
	logic [31:0] b;
	logic [3:0]  opTable[11] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h8, 4'h9, 4'hA, 4'hB,
		4'hC, 4'hD};

	uopDecodeStage #(.ScratchReg(ScratchReg)) uut (
		.clk        (clk),
		.rst        (rst),
		.fetchValid (fetchValid),
		.flush      (flush),
		.instrF     (instrF),
		.ctrlD      (ctrlD),
		.stallD     (stallD)
	);

	always #2 clk = ~clk; // 4 ns period

	// compare every valid control word with the queue head
	always @(posedge clk) begin
		if (!rst && ctrlD.valid) begin
			if (expQ.size() == 0) begin
				$display("unexpected control word %h in test %s", ctrlD, testName);
				errCount++;
			end else begin
				expWord  = expQ.pop_front();
				expStall = stallQ.pop_front();
				if (ctrlD !== expWord) begin
					$display("error %s ctrl expected %h actual %h", testName, expWord, ctrlD);
					errCount++;
				end
				if (stallD !== expStall) begin
					$display("error %s stall expected %b actual %b", testName, expStall, stallD);
					errCount++;
				end
			end
		end else if (!rst && stallD) begin
			$display("stall raised without a valid control word in test %s", testName);
			errCount++;
		end
	end

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v         = {v[30:0], lfsrState[0]}; // one step per bit
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// present an instruction, push its words once the stage takes it
	task automatic issue(input instrWord w);
		int      cnt;
		int      n;
		ctrlWord e0;
		ctrlWord e1;
		cnt = 0;
		expandInstr(w, n, e0, e1);
		fetchValid <= 1'b1;
		instrF     <= w;
		do begin
			@(posedge clk);
			cnt++;
		end while (stallD && cnt < 10);
		if (stallD) begin
			$display("timeout: instruction %h never accepted in test %s", w, testName);
			timedOut = 1'b1;
		end else begin
			expQ.push_back(e0);
			stallQ.push_back(n == 2); // stall only beside a first micro-op
			if (n == 2) begin
				expQ.push_back(e1);
				stallQ.push_back(1'b0);
			end
		end
	endtask

	task automatic idle(input int n);
		fetchValid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// drain the queue, then report the test
	task automatic endTest;
		int cnt;
		cnt = 0;
		fetchValid <= 1'b0;
		while (expQ.size() != 0 && cnt < 20) begin
			@(posedge clk);
			cnt++;
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d control words missing in test %s", expQ.size(), testName);
			timedOut = 1'b1;
			expQ.delete();
			stallQ.delete();
		end
		testCount++;
		$display("test %s: %s", testName, (errCount == errBefore) ? "ok" : "failed");
	endtask

	task automatic startTest(input string name);
		testName  = name;
		errBefore = errCount;
	endtask

	initial begin
		rst        = 1'b1;
		fetchValid = 1'b0;
		flush      = 1'b0;
		instrF     = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		startTest("plain");
		issue(32'hE2821045); // ADD r1, r2, #0x45
		issue(32'hE0543185); // SUBS r3, r4, r5, LSL #3
		issue(32'hE3560001); // CMP r6, #1
		issue(32'hE1A07FC8); // MOV r7, r8, ASR #31
		endTest();

		startTest("rsr");
		issue(32'hE0821413); // ADD r1, r2, r3, LSL r4
		issue(32'hE19A9C7B); // ORRS r9, r10, r11, ROR r12
		endTest();

		startTest("mla");
		issue(32'hE0214392); // MLA r1, r2, r3, r4
		issue(32'hE0356798); // MLAS r5, r8, r7, r6
		issue(32'hE0020493); // MUL r2, r3, r4
		endTest();

		startTest("stallHold");
		issue(32'hE0821413);
		fetchValid <= 1'b1;
		instrF     <= 32'hE3A0F055; // junk during the stall cycle
		@(posedge clk);
		if (!stallD) begin
			$display("stall was not raised for an expanded instruction in test %s", testName);
			errCount++;
		end
		issue(32'hE2821045);
		issue(32'hE0214392);
		endTest();

		startTest("flush");
		issue(32'hE0821413);
		fetchValid <= 1'b0;
		flush      <= 1'b1; // during the first micro-op
		void'(expQ.pop_back()); // second word is dropped
		void'(stallQ.pop_back());
		@(posedge clk);
		flush <= 1'b0;
		@(posedge clk);
		if (ctrlD.valid || stallD) begin
			$display("error flush expected bubble actual valid %b stall %b", ctrlD.valid, stallD);
			errCount++;
		end
		issue(32'hE3560001);
		endTest();

		startTest("random");
		for (int k = 0; k < 200; k++) begin
			takeBits(2, b);
			case (b[1:0])
				2'd0: begin
					takeBits(4, b);
					rw = {b[3:0], 3'b001, 4'h0, 21'h0}; // immediate, bit 7 low
					takeBits(4, b);
					rw[24:21] = opTable[b % 11];
					takeBits(20, b);
					rw[20:8] = b[12:0];
					rw[6:0]  = b[19:13];
				end
				2'd1: begin
					takeBits(4, b);
					rw = {b[3:0], 3'b000, 25'h0}; // immediate shift, bit 4 low
					takeBits(4, b);
					rw[24:21] = opTable[b % 11];
					takeBits(20, b);
					rw[20:5] = b[15:0];
					rw[3:0]  = b[19:16];
				end
				2'd2: begin
					takeBits(4, b);
					rw = {b[3:0], 3'b000, 25'h10}; // RSR
					takeBits(4, b);
					rw[24:21] = opTable[b % 11];
					takeBits(19, b);
					rw[20:8] = b[12:0];
					rw[6:5]  = b[14:13];
					rw[3:0]  = b[18:15];
				end
				default: begin
					takeBits(22, b);
					rw = {b[3:0], 6'b0, b[5:4], b[17:6], 4'b1001, b[21:18]}; // multiply
				end
			endcase
			issue(rw);
			takeBits(3, b);
			if (b[1:0] == 2'b00) begin
				idle(1 + int'(b[2])); // valid gap of one or two cycles
			end
		end
		endTest();

		$display("tests %0d, errors %0d, timeouts %0d", testCount, errCount, timedOut);
		if (errCount == 0 && !timedOut) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
